/* project.f */
logic/pluck_pkg.sv
logic/mem_port_if.sv
logic/pluck_debounce.sv
logic/string_voice.sv
logic/delay_ram_arbiter.sv
logic/delay_ram.sv
logic/voice_mixer.sv
logic/pluck_synth.sv
verification/pluck_synth_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = pluck_synth_tb
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/pluck_synth_tb.sv */
`timescale 1ns/100ps

module pluck_synth_tb;

	localparam int          DEBOUNCE     = 4;
	localparam logic [15:0] SEED_0       = 16'hACE1;
	localparam logic [15:0] SEED_1       = 16'h1D2F;
	// Samples consumed by all tests together: 20 + 62 + 40 + 600 + 30 + 60.
	localparam int          TOTAL_SAMPLES  = 812;
	localparam int          TIMEOUT_CYCLES = 20 * TOTAL_SAMPLES + 2000;

	logic              clk;
	logic              trig_reset;
	logic              trig_0;
	logic              trig_1;
	pluck_pkg::len_t   length_0;
	pluck_pkg::len_t   length_1;
	logic              out_ready;
	pluck_pkg::mix_t   mix;
	logic              out_valid;

	// Reference model of both strings.
	logic signed [15:0] mdl_buf [2][256];
	logic [15:0]        mdl_lfsr [2];
	logic signed [15:0] mdl_last [2];
	int                 mdl_len [2];
	int                 mdl_pos [2];
	int                 mdl_load [2];
	bit                 mdl_active [2];
	bit                 mdl_pend [2];
	int                 mdl_pend_cnt [2];
	int                 mdl_pend_len [2];

	pluck_pkg::sample_t exp_0;
	pluck_pkg::sample_t exp_1;
	pluck_pkg::mix_t    exp_mix;
	pluck_pkg::mix_t    held_mix;
	pluck_pkg::mix_t    prev_mix;
	logic               held;
	logic               was_held;
	int                 consumed;
	int                 cycles;
	int                 err_count;
	integer             seed;

	pluck_synth #(
		.DEBOUNCE_CYCLES(DEBOUNCE),
		.NOISE_SEED_0   (SEED_0),
		.NOISE_SEED_1   (SEED_1)
	) i_dut (
		.clk       (clk),
		.trig_reset(trig_reset),
		.trig_0    (trig_0),
		.trig_1    (trig_1),
		.length_0  (length_0),
		.length_1  (length_1),
		.out_ready (out_ready),
		.mix       (mix),
		.out_valid (out_valid)
	);

	always #2 clk = ~clk;

	function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? pluck_pkg::LFSR_TAPS : 16'h0000);
	endfunction

	function automatic int clamp_len(input int len);
		return (len < pluck_pkg::MIN_LEN) ? pluck_pkg::MIN_LEN : len;
	endfunction

	// Produces the next sample of voice k, one step of the string.
	function automatic logic signed [15:0] voice_next(input int k);
		logic signed [15:0] w;
		logic signed [16:0] sum;
		if (mdl_pend[k] && mdl_pend_cnt[k] == 0)
		begin
			mdl_pend[k]   = 1'b0;
			mdl_pos[k]    = 0;
			mdl_last[k]   = '0;
			mdl_len[k]    = mdl_pend_len[k];
			mdl_load[k]   = mdl_pend_len[k];
			mdl_active[k] = 1'b1;
		end
		if (!mdl_active[k])
		begin
			w = '0;
		end
		else
		begin
			if (mdl_load[k] > 0)
			begin
				w           = mdl_lfsr[k];
				mdl_lfsr[k] = lfsr_advance(mdl_lfsr[k]);
				mdl_load[k] = mdl_load[k] - 1;
			end
			else
			begin
				sum = mdl_buf[k][mdl_pos[k]] + mdl_last[k];
				w   = 16'(sum >>> 1);
			end
			mdl_buf[k][mdl_pos[k]] = w;
			mdl_last[k]            = w;
			mdl_pos[k]             = (mdl_pos[k] + 1) % mdl_len[k];
		end
		// Samples already in flight when the pluck came still follow the old string.
		if (mdl_pend[k] && mdl_pend_cnt[k] > 0)
		begin
			mdl_pend_cnt[k] = mdl_pend_cnt[k] - 1;
		end
		return w;
	endfunction

	// While stalled, the mixer register and the presented sample are two steps ahead.
	task automatic model_pluck(input int k, input int len);
		mdl_pend[k]     = 1'b1;
		mdl_pend_cnt[k] = 2;
		mdl_pend_len[k] = clamp_len(len);
	endtask

	always @(posedge clk)
	begin
		if (out_valid && out_ready)
		begin
			exp_0    = voice_next(0);
			exp_1    = voice_next(1);
			exp_mix  = exp_0 + exp_1;
			consumed = consumed + 1;
			assert (mix === exp_mix)
			else
			begin
				err_count++;
				$display("ERR %0t: mix expected %0d, got %0d", $time, exp_mix, mix);
				$display("tests failed");
				$fatal(1);
			end
		end
	end

	// A held output must not change until it is taken.
	always @(posedge clk)
	begin
		was_held = held;
		prev_mix = held_mix;
		held     = out_valid && !out_ready && trig_reset;
		held_mix = mix;
		if (was_held)
		begin
			assert (out_valid === 1'b1 && mix === prev_mix)
			else
			begin
				err_count++;
				$display("ERR %0t: mix changed from %0d to %0d while stalled", $time, prev_mix, mix);
				$display("tests failed");
				$fatal(1);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run went on for %0d cycles without finishing", cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	// Consumes n outputs, then leaves the stream stalled.
	task automatic run_samples(input int n, input bit random_ready);
		int target;
		int rnd;
		target = consumed + n;
		@(negedge clk);
		while (consumed < target)
		begin
			rnd       = $random(seed);
			out_ready = random_ready ? rnd[0] : 1'b1;
			@(negedge clk);
		end
		out_ready = 1'b0;
	endtask

	task automatic press_trigger(input int k, input int cycles_high);
		repeat (30) @(negedge clk);
		if (k == 0)
		begin
			trig_0 = 1'b1;
		end
		else
		begin
			trig_1 = 1'b1;
		end
		repeat (cycles_high) @(negedge clk);
		trig_0 = 1'b0;
		trig_1 = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic pluck_voice(input int k, input int len);
		if (k == 0)
		begin
			length_0 = pluck_pkg::len_t'(len);
		end
		else
		begin
			length_1 = pluck_pkg::len_t'(len);
		end
		press_trigger(k, DEBOUNCE + 2);
		model_pluck(k, len);
	endtask

	task automatic reset_and_silence();
		trig_reset = 1'b0;
		repeat (3) @(negedge clk);
		assert (out_valid === 1'b0)
		else
		begin
			err_count++;
			$display("ERR %0t: out_valid is %b during reset, expected 0", $time, out_valid);
			$display("tests failed");
			$fatal(1);
		end
		trig_reset = 1'b1;
		// Unplucked voices give silence.
		run_samples(20, 1'b0);
	endtask

	task automatic single_pluck();
		pluck_voice(0, 10);
		// Two silent samples are still in flight, then 10 noise and 50 averaged ones.
		run_samples(62, 1'b0);
	endtask

	task automatic length_clamp();
		pluck_voice(1, 2);
		run_samples(40, 1'b0);
	endtask

	task automatic two_voices_backpressure();
		pluck_voice(0, 37);
		pluck_voice(1, 200);
		run_samples(600, 1'b1);
	endtask

	task automatic debounce_filter();
		// A two-cycle glitch is shorter than the debounce window.
		press_trigger(0, 2);
		run_samples(30, 1'b0);
		pluck_voice(0, 37);
		run_samples(60, 1'b0);
	endtask

	initial
	begin
		clk        = 1'b0;
		trig_reset = 1'b0;
		trig_0     = 1'b0;
		trig_1     = 1'b0;
		length_0   = '0;
		length_1   = '0;
		out_ready  = 1'b0;
		held       = 1'b0;
		held_mix   = '0;
		consumed   = 0;
		cycles     = 0;
		err_count  = 0;
		seed       = 32'hc13c_ec86;
		for (int k = 0; k < 2; k++)
		begin
			mdl_active[k]   = 1'b0;
			mdl_pend[k]     = 1'b0;
			mdl_pend_cnt[k] = 0;
			mdl_pend_len[k] = pluck_pkg::MIN_LEN;
			mdl_len[k]      = pluck_pkg::MIN_LEN;
			mdl_pos[k]      = 0;
			mdl_load[k]     = 0;
			mdl_last[k]     = '0;
		end
		mdl_lfsr[0] = SEED_0;
		mdl_lfsr[1] = SEED_1;

		reset_and_silence();
		single_pluck();
		length_clamp();
		two_voices_backpressure();
		debounce_filter();

		if (err_count == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* logic/pluck_synth.sv */
`timescale 1ns/100ps

module pluck_synth #(
	parameter int          DEBOUNCE_CYCLES = 16,
	parameter logic [15:0] NOISE_SEED_0    = 16'hACE1,
	parameter logic [15:0] NOISE_SEED_1    = 16'h1D2F
) (
	input  logic            clk,
	input  logic            trig_reset,
	input  logic            trig_0,
	input  logic            trig_1,
	input  pluck_pkg::len_t length_0,
	input  pluck_pkg::len_t length_1,
	input  logic            out_ready,
	output pluck_pkg::mix_t mix,
	output logic            out_valid
);

	localparam int RAM_DEPTH = pluck_pkg::NUM_VOICES * pluck_pkg::MAX_LEN;

	logic                 pluck_0;
	logic                 pluck_1;
	pluck_pkg::sample_t   sample_0;
	pluck_pkg::sample_t   sample_1;
	logic                 sample_valid_0;
	logic                 sample_valid_1;
	logic                 sample_ready_0;
	logic                 sample_ready_1;
	logic                 ram_en;
	logic                 ram_we;
	pluck_pkg::ram_addr_t ram_addr;
	pluck_pkg::sample_t   ram_wdata;
	pluck_pkg::sample_t   ram_rdata;

	mem_port_if mem_0 ();
	mem_port_if mem_1 ();

	pluck_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) i_debounce_0 (
		.clk       (clk),
		.trig_reset(trig_reset),
		.trig      (trig_0),
		.pluck     (pluck_0)
	);

	pluck_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) i_debounce_1 (
		.clk       (clk),
		.trig_reset(trig_reset),
		.trig      (trig_1),
		.pluck     (pluck_1)
	);

	// Voice k owns the RAM words from k * MAX_LEN upward.
	string_voice #(
		.VOICE_BASE(pluck_pkg::ram_addr_t'(0)),
		.NOISE_SEED(NOISE_SEED_0)
	) i_voice_0 (
		.clk         (clk),
		.trig_reset  (trig_reset),
		.pluck       (pluck_0),
		.length      (length_0),
		.sample_ready(sample_ready_0),
		.sample      (sample_0),
		.sample_valid(sample_valid_0),
		.mem         (mem_0.voice)
	);

	string_voice #(
		.VOICE_BASE(pluck_pkg::ram_addr_t'(pluck_pkg::MAX_LEN)),
		.NOISE_SEED(NOISE_SEED_1)
	) i_voice_1 (
		.clk         (clk),
		.trig_reset  (trig_reset),
		.pluck       (pluck_1),
		.length      (length_1),
		.sample_ready(sample_ready_1),
		.sample      (sample_1),
		.sample_valid(sample_valid_1),
		.mem         (mem_1.voice)
	);

	delay_ram_arbiter i_arbiter (
		.clk       (clk),
		.trig_reset(trig_reset),
		.ram_rdata (ram_rdata),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.port_0    (mem_0.arbiter),
		.port_1    (mem_1.arbiter)
	);

	delay_ram #(
		.DEPTH(RAM_DEPTH)
	) i_ram (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.addr (ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	voice_mixer i_mixer (
		.clk           (clk),
		.trig_reset    (trig_reset),
		.sample_0      (sample_0),
		.sample_valid_0(sample_valid_0),
		.sample_1      (sample_1),
		.sample_valid_1(sample_valid_1),
		.out_ready     (out_ready),
		.sample_ready_0(sample_ready_0),
		.sample_ready_1(sample_ready_1),
		.mix           (mix),
		.out_valid     (out_valid)
	);

endmodule

/* logic/voice_mixer.sv */
`timescale 1ns/100ps

module voice_mixer (
	input  logic               clk,
	input  logic               trig_reset,
	input  pluck_pkg::sample_t sample_0,
	input  logic               sample_valid_0,
	input  pluck_pkg::sample_t sample_1,
	input  logic               sample_valid_1,
	input  logic               out_ready,
	output logic               sample_ready_0,
	output logic               sample_ready_1,
	output pluck_pkg::mix_t    mix,
	output logic               out_valid
);

	localparam int MSB = pluck_pkg::SAMPLE_W - 1;

	logic accept;

	// Both voices are taken together, so they never drift apart by a sample.
	assign accept = sample_valid_0 && sample_valid_1 && (!out_valid || out_ready);

	assign sample_ready_0 = accept;
	assign sample_ready_1 = accept;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			mix <= {sample_0[MSB], sample_0} + {sample_1[MSB], sample_1};
		end
	end

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			out_valid <= 1'b0;
		end
		else if (accept)
		begin
			out_valid <= 1'b1;
		end
		else if (out_ready)
		begin
			out_valid <= 1'b0;
		end
	end

endmodule

/* logic/delay_ram.sv */
`timescale 1ns/100ps

module delay_ram #(
	parameter int DEPTH = 512
) (
	input  logic                 clk,
	input  logic                 en,
	input  logic                 we,
	input  pluck_pkg::ram_addr_t addr,
	input  pluck_pkg::sample_t   wdata,
	output pluck_pkg::sample_t   rdata
);

	pluck_pkg::sample_t mem [DEPTH];

	// One access per cycle. Read data appears on the following cycle.
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
			begin
				mem[addr] <= wdata;
			end
			else
			begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

/* logic/delay_ram_arbiter.sv */
`timescale 1ns/100ps

module delay_ram_arbiter (
	input  logic                 clk,
	input  logic                 trig_reset,
	input  pluck_pkg::sample_t   ram_rdata,
	output logic                 ram_en,
	output logic                 ram_we,
	output pluck_pkg::ram_addr_t ram_addr,
	output pluck_pkg::sample_t   ram_wdata,
	mem_port_if.arbiter          port_0,
	mem_port_if.arbiter          port_1
);

	logic grant_0;
	logic grant_1;
	logic last_grant_1;
	logic rd_pend_0;
	logic rd_pend_1;

	// Voice 0 wins a tie only if voice 1 had the last grant.
	assign grant_0 = port_0.req_valid && (!port_1.req_valid || last_grant_1);
	assign grant_1 = port_1.req_valid && !grant_0;

	assign port_0.req_ready = grant_0;
	assign port_1.req_ready = grant_1;

	assign ram_en    = grant_0 || grant_1;
	assign ram_we    = (grant_0 && port_0.we) || (grant_1 && port_1.we);
	assign ram_addr  = grant_1 ? port_1.addr : port_0.addr;
	assign ram_wdata = grant_1 ? port_1.wdata : port_0.wdata;

	// Both voices see the RAM output, only the owner of the read sees it as valid.
	assign port_0.rdata       = ram_rdata;
	assign port_1.rdata       = ram_rdata;
	assign port_0.rdata_valid = rd_pend_0;
	assign port_1.rdata_valid = rd_pend_1;

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			last_grant_1 <= 1'b0;
			rd_pend_0    <= 1'b0;
			rd_pend_1    <= 1'b0;
		end
		else
		begin
			rd_pend_0 <= grant_0 && !port_0.we;
			rd_pend_1 <= grant_1 && !port_1.we;
			if (grant_0)
			begin
				last_grant_1 <= 1'b0;
			end
			else if (grant_1)
			begin
				last_grant_1 <= 1'b1;
			end
		end
	end

endmodule

/* logic/string_voice.sv */
`timescale 1ns/100ps

module string_voice #(
	parameter pluck_pkg::ram_addr_t VOICE_BASE = '0,
	parameter logic [15:0]          NOISE_SEED = 16'hACE1
) (
	input  logic               clk,
	input  logic               trig_reset,
	input  logic               pluck,
	input  pluck_pkg::len_t    length,
	input  logic               sample_ready,
	output pluck_pkg::sample_t sample,
	output logic               sample_valid,
	mem_port_if.voice          mem
);

	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_wait,
		st_write,
		st_present
	} state_t;

	state_t             state;
	logic [15:0]        lfsr;
	logic [15:0]        lfsr_next;
	pluck_pkg::len_t    pos;
	pluck_pkg::len_t    len_q;
	pluck_pkg::len_t    load_cnt;
	pluck_pkg::len_t    pend_len;
	pluck_pkg::len_t    len_clamped;
	pluck_pkg::sample_t last;
	pluck_pkg::sample_t w_next;
	logic signed [16:0] avg_sum;
	logic               pend;
	logic               active;

	assign len_clamped = (length < pluck_pkg::len_t'(pluck_pkg::MIN_LEN)) ?
		pluck_pkg::len_t'(pluck_pkg::MIN_LEN) : length;

	assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? pluck_pkg::LFSR_TAPS : 16'h0000);

	// The average is formed on 17 bits so the sum of two extremes keeps its sign.
	always_comb
	begin
		avg_sum = mem.rdata + last;
		if (load_cnt != '0)
		begin
			w_next = lfsr;
		end
		else
		begin
			w_next = avg_sum[16:1];
		end
	end

	// Reads and writes of a step go to the same word of this voice's region.
	assign mem.req_valid = (state == st_read) || (state == st_write);
	assign mem.we        = (state == st_write);
	assign mem.addr      = VOICE_BASE + pluck_pkg::ram_addr_t'(pos);
	assign mem.wdata     = sample;

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			state        <= st_idle;
			sample_valid <= 1'b0;
			lfsr         <= NOISE_SEED;
			pos          <= '0;
			load_cnt     <= '0;
			pend         <= 1'b0;
			active       <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					// A pending pluck restarts the string at this step start.
					if (pend)
					begin
						pend     <= 1'b0;
						pos      <= '0;
						last     <= '0;
						len_q    <= pend_len;
						load_cnt <= pend_len;
						active   <= 1'b1;
						state    <= st_read;
					end
					else if (active)
					begin
						state <= st_read;
					end
					else
					begin
						sample       <= '0;
						sample_valid <= 1'b1;
						state        <= st_present;
					end
				end
				st_read:
				begin
					if (mem.req_ready)
					begin
						state <= st_wait;
					end
				end
				st_wait:
				begin
					if (mem.rdata_valid)
					begin
						sample <= w_next;
						if (load_cnt != '0)
						begin
							lfsr     <= lfsr_next;
							load_cnt <= load_cnt - 1'b1;
						end
						state <= st_write;
					end
				end
				st_write:
				begin
					if (mem.req_ready)
					begin
						last         <= sample;
						pos          <= (pos == len_q - 1'b1) ? '0 : pos + 1'b1;
						sample_valid <= 1'b1;
						state        <= st_present;
					end
				end
				default:
				begin
					if (sample_ready)
					begin
						sample_valid <= 1'b0;
						state        <= st_idle;
					end
				end
			endcase

			// A new pluck wins over the clear in st_idle and applies at the next step.
			if (pluck)
			begin
				pend     <= 1'b1;
				pend_len <= len_clamped;
			end
		end
	end

endmodule

/* logic/pluck_debounce.sv */
`timescale 1ns/100ps

module pluck_debounce #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic clk,
	input  logic trig_reset,
	input  logic trig,
	output logic pluck
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [CNT_W-1:0] high_cnt;
	logic             armed;

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			high_cnt <= '0;
			armed    <= 1'b0;
			pluck    <= 1'b0;
		end
		else if (!trig)
		begin
			// A low level re-arms the detector for the next press.
			high_cnt <= '0;
			armed    <= 1'b1;
			pluck    <= 1'b0;
		end
		else
		begin
			if (high_cnt != CNT_W'(DEBOUNCE_CYCLES))
			begin
				high_cnt <= high_cnt + 1'b1;
			end
			pluck <= armed && (high_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));
			if (high_cnt == CNT_W'(DEBOUNCE_CYCLES - 1))
			begin
				armed <= 1'b0;
			end
		end
	end

endmodule

/* logic/mem_port_if.sv */
`timescale 1ns/100ps

// Request channel from one voice into the shared delay RAM.
interface mem_port_if;

	logic                 req_valid;
	logic                 req_ready;
	logic                 we;
	pluck_pkg::ram_addr_t addr;
	pluck_pkg::sample_t   wdata;
	pluck_pkg::sample_t   rdata;
	logic                 rdata_valid;

	modport voice (
		output req_valid,
		output we,
		output addr,
		output wdata,
		input  req_ready,
		input  rdata,
		input  rdata_valid
	);

	modport arbiter (
		input  req_valid,
		input  we,
		input  addr,
		input  wdata,
		output req_ready,
		output rdata,
		output rdata_valid
	);

endinterface

/* logic/pluck_pkg.sv */
package pluck_pkg;

	// Width of one audio sample in the delay lines.
	localparam int SAMPLE_W = 16;

	// Two voices share the delay RAM.
	localparam int NUM_VOICES = 2;

	// Each voice owns a region of MAX_LEN words.
	localparam int MAX_LEN = 256;

	// Shorter strings are stretched to this length.
	localparam int MIN_LEN = 4;

	// Galois feedback mask of the 16-bit noise generator.
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// One guard bit so the sum of two voices cannot overflow.
	typedef logic signed [SAMPLE_W:0] mix_t;

	// Covers NUM_VOICES * MAX_LEN = 512 words.
	typedef logic [8:0] ram_addr_t;

	typedef logic [7:0] len_t;

endpackage
